// ==== bp_defs.svh ====
`ifndef BP_DEFS_SVH
`define BP_DEFS_SVH

// Table sizes
`define BTB_ENTRIES     64
`define BHT_ENTRIES     256
`define BTB_INDEX_BITS  6
`define BHT_INDEX_BITS  8

// Index bit ranges, both start just above the byte offset
`define BTB_IDX_LSB     2
`define BTB_IDX_MSB     (`BTB_IDX_LSB + `BTB_INDEX_BITS - 1)
`define BHT_IDX_LSB     2
`define BHT_IDX_MSB     (`BHT_IDX_LSB + `BHT_INDEX_BITS - 1)

// BTB tag is every PC bit above the index
`define BTB_TAG_BITS    (32 - `BTB_IDX_MSB - 1)

`define RESET_PC        32'h0000_0000
`define CTR_RESET       2'b01

`endif

// ==== branchHistoryTable.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "bp_defs.svh"

module branchHistoryTable
    import rvIsaPkg::*;
    import predPkg::*;
(
    input  logic     clk,
    input  logic     rstN,
    input  pc_t      fetchPc,
    input  resolve_t resolve,
    output logic     predictTaken
);

    localparam bhtCtr_t ctrInit = `CTR_RESET;

    logic [`BHT_INDEX_BITS-1:0] fetchIndex;
    logic [`BHT_INDEX_BITS-1:0] trainIndex;
    bhtCtr_t                    fetchCtr;
    bhtCtr_t                    trainCtr;
    bhtCtr_t                    nextCtr;
    logic                       train;

    assign fetchIndex = fetchPc[`BHT_IDX_MSB:`BHT_IDX_LSB];
    assign trainIndex = resolve.pc[`BHT_IDX_MSB:`BHT_IDX_LSB];

    // Upper bit set means 2 or 3, i.e. taken
    assign predictTaken = fetchCtr[1];

    //------------------------------------------------------------
    // Training, conditional branches only
    //------------------------------------------------------------
    assign train = resolve.valid && (resolve.opcode == OPC_BRANCH);

    always_comb begin
        nextCtr = trainCtr;
        if (resolve.taken) begin
            if (trainCtr != CTR_MAX) begin
                nextCtr = trainCtr + 2'd1;
            end
        end else if (trainCtr != CTR_MIN) begin
            nextCtr = trainCtr - 2'd1;
        end
    end

    // No write when the counter is already saturated
    predTable #(
        .entryT (bhtCtr_t),
        .depth  (`BHT_ENTRIES)
    ) bhtTable (
        .clk        (clk),
        .rstN       (rstN),
        .rdIndex    (fetchIndex),
        .rdEntry    (fetchCtr),
        .rdIndex2   (trainIndex),
        .rdEntry2   (trainCtr),
        .wrEn       (train && (nextCtr != trainCtr)),
        .wrIndex    (trainIndex),
        .wrEntry    (nextCtr),
        .clearEntry (ctrInit)
    );

endmodule

`default_nettype wire

// ==== branchPredictor.sv ====
`timescale 1ns/100ps
`default_nettype none

// Branch prediction front end, fetch PC plus BTB and BHT
module branchPredictor
    import rvIsaPkg::*;
    import predPkg::*;
(
    input  logic     clk,
    input  logic     rstN,
    input  logic     stall,
    input  resolve_t resolve,
    output pc_t      fetchPc,
    output pc_t      predNextPc,
    output logic     redirect
);

    btbLookup_t btbLookup;
    logic       predictTaken;

    //------------------------------------------------------------
    // Parallel lookups on the fetch PC
    //------------------------------------------------------------
    branchTargetBuffer btb (
        .clk     (clk),
        .rstN    (rstN),
        .fetchPc (fetchPc),
        .resolve (resolve),
        .lookup  (btbLookup)
    );

    branchHistoryTable bht (
        .clk          (clk),
        .rstN         (rstN),
        .fetchPc      (fetchPc),
        .resolve      (resolve),
        .predictTaken (predictTaken)
    );

    //------------------------------------------------------------
    // Next PC selection and redirect
    //------------------------------------------------------------
    nextPcGen npcGen (
        .clk          (clk),
        .rstN         (rstN),
        .stall        (stall),
        .lookup       (btbLookup),
        .predictTaken (predictTaken),
        .resolve      (resolve),
        .fetchPc      (fetchPc),
        .predNextPc   (predNextPc),
        .redirect     (redirect)
    );

endmodule

`default_nettype wire

// ==== branchPredictor_properties.sv ====
`timescale 1ns/100ps
`default_nettype none

module branchPredictorProperties
    import rvIsaPkg::*;
    import predPkg::*;
(
    input logic     clk,
    input logic     rstN,
    input logic     stall,
    input resolve_t resolve,
    input pc_t      fetchPc,
    input logic     redirect
);

    pc_t actualNextPc;

    // Number of failed assertions so far
    int unsigned failCount = 0;

    // Where the resolved instruction really went
    assign actualNextPc = resolve.taken ? resolve.target : resolve.pc + 32'd4;

    fetchAligned: assert property (
        @(posedge clk) disable iff (!rstN) fetchPc[1:0] == 2'b00
    ) else begin
        failCount++;
        $error("fetchPc %h is not word aligned", fetchPc);
    end

    //------------------------------------------------------------
    // Fetch PC update rules
    //------------------------------------------------------------
    redirectTarget: assert property (
        @(posedge clk) disable iff (!rstN) redirect |=> (fetchPc == $past(actualNextPc))
    ) else begin
        failCount++;
        $error("fetchPc %h did not follow the redirect", fetchPc);
    end

    stallHold: assert property (
        @(posedge clk) disable iff (!rstN) (stall && !redirect) |=> (fetchPc == $past(fetchPc))
    ) else begin
        failCount++;
        $error("fetchPc %h moved during stall", fetchPc);
    end

endmodule

`default_nettype wire

// ==== branchTargetBuffer.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "bp_defs.svh"

module branchTargetBuffer
    import rvIsaPkg::*;
    import predPkg::*;
(
    input  logic       clk,
    input  logic       rstN,
    input  pc_t        fetchPc,
    input  resolve_t   resolve,
    output btbLookup_t lookup
);

    localparam btbEntry_t emptyEntry = '0;

    logic [`BTB_INDEX_BITS-1:0] fetchIndex;
    logic [`BTB_INDEX_BITS-1:0] resolveIndex;
    btbTag_t                    fetchTag;
    btbTag_t                    resolveTag;
    btbEntry_t                  fetchEntry;
    btbEntry_t                  resolveEntry;
    btbEntry_t                  newEntry;
    logic                       isJump;
    logic                       allocate;

    //------------------------------------------------------------
    // Address split
    //------------------------------------------------------------
    assign fetchIndex   = fetchPc[`BTB_IDX_MSB:`BTB_IDX_LSB];
    assign fetchTag     = fetchPc[$bits(pc_t)-1:`BTB_IDX_MSB+1];
    assign resolveIndex = resolve.pc[`BTB_IDX_MSB:`BTB_IDX_LSB];
    assign resolveTag   = resolve.pc[$bits(pc_t)-1:`BTB_IDX_MSB+1];

    // Fetch side lookup
    assign lookup.hit    = fetchEntry.valid && (fetchEntry.tag == fetchTag);
    assign lookup.target = fetchEntry.target;

    //------------------------------------------------------------
    // Allocation on a taken branch or jal
    //------------------------------------------------------------
    assign isJump = (resolve.opcode == OPC_BRANCH) || (resolve.opcode == OPC_JAL);

    assign newEntry.valid  = 1'b1;
    assign newEntry.tag    = resolveTag;
    assign newEntry.target = resolve.target;

    // An alias at the same index is simply overwritten,
    // an identical entry is left alone
    assign allocate = resolve.valid && resolve.taken && isJump
                      && (resolveEntry != newEntry);

    predTable #(
        .entryT (btbEntry_t),
        .depth  (`BTB_ENTRIES)
    ) btbTable (
        .clk        (clk),
        .rstN       (rstN),
        .rdIndex    (fetchIndex),
        .rdEntry    (fetchEntry),
        .rdIndex2   (resolveIndex),
        .rdEntry2   (resolveEntry),
        .wrEn       (allocate),
        .wrIndex    (resolveIndex),
        .wrEntry    (newEntry),
        .clearEntry (emptyEntry)
    );

endmodule

`default_nettype wire

// ==== build.f ====
+incdir+.
rvIsaPkg.sv
predPkg.sv
predTable.sv
branchTargetBuffer.sv
branchHistoryTable.sv
nextPcGen.sv
branchPredictor.sv
branchPredictor_properties.sv
tbBranchPredictor.sv

// ==== nextPcGen.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "bp_defs.svh"

module nextPcGen
    import rvIsaPkg::*;
    import predPkg::*;
(
    input  logic       clk,
    input  logic       rstN,
    input  logic       stall,
    input  btbLookup_t lookup,
    input  logic       predictTaken,
    input  resolve_t   resolve,
    output pc_t        fetchPc,
    output pc_t        predNextPc,
    output logic       redirect
);

    pc_t seqPc;
    pc_t actualNextPc;
    pc_t nextFetchPc;

    //------------------------------------------------------------
    // Prediction for the current fetch
    //------------------------------------------------------------
    assign seqPc = fetchPc + INSTR_BYTES;

    // BTB target only when the direction counter agrees
    assign predNextPc = (lookup.hit && predictTaken) ? lookup.target : seqPc;

    //------------------------------------------------------------
    // Mispredict check on the resolved instruction
    //------------------------------------------------------------
    assign actualNextPc = resolve.taken ? resolve.target : resolve.pc + INSTR_BYTES;

    assign redirect = resolve.valid && (actualNextPc != resolve.predNextPc);

    // Redirect wins over stall
    always_comb begin
        if (redirect) begin
            nextFetchPc = actualNextPc;
        end else if (!stall) begin
            nextFetchPc = predNextPc;
        end else begin
            nextFetchPc = fetchPc;
        end
    end

    // Fetch PC register
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            fetchPc <= `RESET_PC;
        end else begin
            fetchPc <= nextFetchPc;
        end
    end

endmodule

`default_nettype wire

// ==== predPkg.sv ====
`default_nettype none

`include "bp_defs.svh"

package predPkg;

    import rvIsaPkg::*;

    typedef logic [`BTB_TAG_BITS-1:0] btbTag_t;

    // One BTB slot
    typedef struct packed {
        logic    valid;
        btbTag_t tag;
        pc_t     target;
    } btbEntry_t;

    // Two-bit saturating direction counter
    typedef logic [1:0] bhtCtr_t;

    localparam bhtCtr_t CTR_MIN = 2'b00;
    localparam bhtCtr_t CTR_MAX = 2'b11;

    // BTB result for the fetch PC
    typedef struct packed {
        logic hit;
        pc_t  target;
    } btbLookup_t;

    //------------------------------------------------------------
    // Execute stage report of a resolved instruction
    //------------------------------------------------------------
    typedef struct packed {
        logic    valid;
        opcode_t opcode;
        pc_t     pc;
        logic    taken;
        pc_t     target;
        pc_t     predNextPc;   // what fetch went to after this one
    } resolve_t;

endpackage

`default_nettype wire

// ==== predTable.sv ====
`timescale 1ns/100ps
`default_nettype none

// Direct-mapped table, shared by the BTB and the BHT
module predTable #(
    parameter type         entryT = logic,
    parameter int unsigned depth  = 16
) (
    input  logic                     clk,
    input  logic                     rstN,
    input  logic [$clog2(depth)-1:0] rdIndex,
    output entryT                    rdEntry,
    input  logic [$clog2(depth)-1:0] rdIndex2,
    output entryT                    rdEntry2,
    input  logic                     wrEn,
    input  logic [$clog2(depth)-1:0] wrIndex,
    input  entryT                    wrEntry,
    input  entryT                    clearEntry
);

    entryT entries [depth];

    // Two combinational read ports
    assign rdEntry  = entries[rdIndex];
    assign rdEntry2 = entries[rdIndex2];

    //------------------------------------------------------------
    // Single write port, whole table cleared on reset
    //------------------------------------------------------------
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            for (int i = 0; i < depth; i++) begin
                entries[i] <= clearEntry;
            end
        end else if (wrEn) begin
            entries[wrIndex] <= wrEntry;
        end
    end

endmodule

`default_nettype wire

// ==== run.sh ====
#!/bin/sh
# Build and run the branch predictor testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --assert --timing --timescale 1ns/100ps \
    --top-module tbBranchPredictor -f build.f -o simBranchPredictor
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/simBranchPredictor +verilator+error+limit+100)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qF "*** TEST PASSED ***"; then
    exit 0
fi
exit 1

// ==== rvIsaPkg.sv ====
`default_nettype none

package rvIsaPkg;

    // One instruction address
    typedef logic [31:0] pc_t;

    // Major opcode, inst[6:0]
    typedef logic [6:0] opcode_t;

    //------------------------------------------------------------
    // Opcodes the predictor cares about
    //------------------------------------------------------------
    localparam opcode_t OPC_BRANCH = 7'b1100011;
    localparam opcode_t OPC_JAL    = 7'b1101111;

    // Fixed instruction size in RV32I, no compressed set
    localparam int unsigned INSTR_BYTES = 4;

endpackage

`default_nettype wire

// ==== tbBranchPredictor.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "bp_defs.svh"

module tbBranchPredictor
    import rvIsaPkg::*;
    import predPkg::*;
();

    // OP-IMM opcode that neither table uses
    localparam opcode_t  OPC_OTHER     = 7'b0010011;
    localparam resolve_t NO_RESOLVE    = '0;
    localparam int       RANDOM_CYCLES = 300;
    // Reset plus directed tests stay well under 50 cycles
    localparam int       TEST_CYCLES   = 50 + RANDOM_CYCLES;
    localparam int       MARGIN_CYCLES = 100;

    logic     clk;
    logic     rstN;
    logic     stall;
    resolve_t resolve;
    pc_t      fetchPc;
    pc_t      predNextPc;
    logic     redirect;

    // Reference model state
    btbEntry_t modelBtb [`BTB_ENTRIES];
    bhtCtr_t   modelCtr [`BHT_ENTRIES];
    pc_t       modelFetchPc;

    int          errorCount      = 0;
    int          checkCount      = 0;
    int          testCount       = 0;
    int          failedTests     = 0;
    int unsigned assertFailsSeen = 0;
    logic        lastRedirect;

    initial clk = 1'b0;
    always #10 clk = ~clk;

    branchPredictor UUT (
        .clk        (clk),
        .rstN       (rstN),
        .stall      (stall),
        .resolve    (resolve),
        .fetchPc    (fetchPc),
        .predNextPc (predNextPc),
        .redirect   (redirect)
    );

    bind branchPredictor branchPredictorProperties props (
        .clk      (clk),
        .rstN     (rstN),
        .stall    (stall),
        .resolve  (resolve),
        .fetchPc  (fetchPc),
        .redirect (redirect)
    );

    //------------------------------------------------------------
    // Reference model
    //------------------------------------------------------------
    function automatic pc_t refPredict(pc_t pc);
        btbEntry_t entry;
        bhtCtr_t   ctr;
        entry = modelBtb[pc[`BTB_IDX_MSB:`BTB_IDX_LSB]];
        ctr   = modelCtr[pc[`BHT_IDX_MSB:`BHT_IDX_LSB]];
        // Target only on a tag hit with a taken counter (2 or 3)
        if (entry.valid && (entry.tag == pc[31:`BTB_IDX_MSB+1]) && (ctr >= 2'd2)) begin
            return entry.target;
        end
        return pc + 32'd4;
    endfunction

    function automatic pc_t refActualNext(resolve_t r);
        return r.taken ? r.target : r.pc + 32'd4;
    endfunction

    task automatic modelReset();
        for (int i = 0; i < `BTB_ENTRIES; i++) begin
            modelBtb[i] = '0;
        end
        for (int i = 0; i < `BHT_ENTRIES; i++) begin
            modelCtr[i] = `CTR_RESET;
        end
        modelFetchPc = `RESET_PC;
    endtask

    task automatic modelTrain(resolve_t r);
        logic [`BTB_INDEX_BITS-1:0] btbIdx;
        logic [`BHT_INDEX_BITS-1:0] bhtIdx;
        btbIdx = r.pc[`BTB_IDX_MSB:`BTB_IDX_LSB];
        bhtIdx = r.pc[`BHT_IDX_MSB:`BHT_IDX_LSB];
        if (r.valid && r.taken && (r.opcode == OPC_BRANCH || r.opcode == OPC_JAL)) begin
            modelBtb[btbIdx] = {1'b1, r.pc[31:`BTB_IDX_MSB+1], r.target};
        end
        if (r.valid && (r.opcode == OPC_BRANCH)) begin
            if (r.taken && (modelCtr[bhtIdx] != 2'd3)) begin
                modelCtr[bhtIdx] = modelCtr[bhtIdx] + 2'd1;
            end else if (!r.taken && (modelCtr[bhtIdx] != 2'd0)) begin
                modelCtr[bhtIdx] = modelCtr[bhtIdx] - 2'd1;
            end
        end
    endtask

    task automatic reportMismatch(string signal, pc_t got, pc_t exp);
        errorCount++;
        $display("Mismatch at %0t ns: %s is %h, expected %h", $time, signal, got, exp);
    endtask

    // Compare at the falling edge and advance the model
    always @(negedge clk) begin : modelCheck
        pc_t  expPred;
        logic expRedirect;
        if (!rstN) begin
            modelReset();
        end else begin
            expPred     = refPredict(modelFetchPc);
            expRedirect = resolve.valid && (refActualNext(resolve) != resolve.predNextPc);
            checkCount++;
            if (fetchPc !== modelFetchPc) begin
                reportMismatch("fetchPc", fetchPc, modelFetchPc);
            end
            if (predNextPc !== expPred) begin
                reportMismatch("predNextPc", predNextPc, expPred);
            end
            if (redirect !== expRedirect) begin
                reportMismatch("redirect", {31'b0, redirect}, {31'b0, expRedirect});
            end
            if (expRedirect) begin
                modelFetchPc = refActualNext(resolve);
            end else if (!stall) begin
                modelFetchPc = expPred;
            end
            modelTrain(resolve);
        end
    end

    //------------------------------------------------------------
    // Stimulus helpers
    //------------------------------------------------------------
    function automatic resolve_t makeResolve(opcode_t opc, pc_t pc, logic taken,
                                             pc_t target, pc_t predNext);
        resolve_t r;
        r.valid      = 1'b1;
        r.opcode     = opc;
        r.pc         = pc;
        r.taken      = taken;
        r.target     = target;
        r.predNextPc = predNext;
        return r;
    endfunction

    function automatic resolve_t randomResolve();
        resolve_t    r;
        int unsigned pick;
        r.valid  = ($urandom % 2) == 0;
        pick     = $urandom % 3;
        r.opcode = (pick == 0) ? OPC_BRANCH : (pick == 1) ? OPC_JAL : OPC_OTHER;
        r.pc     = ($urandom % 128) << 2;
        r.taken  = ($urandom % 2) == 0;
        r.target = ($urandom % 128) << 2;
        // Correct prediction about half the time
        if (($urandom % 2) == 0) begin
            r.predNextPc = r.taken ? r.target : r.pc + 32'd4;
        end else begin
            r.predNextPc = ($urandom % 128) << 2;
        end
        return r;
    endfunction

    task automatic applyCycle(logic stallIn, resolve_t resIn);
        stall   = stallIn;
        resolve = resIn;
        @(negedge clk);
        lastRedirect = redirect;
        @(posedge clk);
        #1;
    endtask

    task automatic expectRedirect(logic exp);
        if (lastRedirect !== exp) begin
            reportMismatch("redirect", {31'b0, lastRedirect}, {31'b0, exp});
        end
    endtask

    // Holds fetch with stall and checks the current fetch and prediction
    task automatic expectFetch(pc_t expFetch, pc_t expPred);
        stall   = 1'b1;
        resolve = NO_RESOLVE;
        @(negedge clk);
        if (fetchPc !== expFetch) begin
            reportMismatch("fetchPc", fetchPc, expFetch);
        end
        if (predNextPc !== expPred) begin
            reportMismatch("predNextPc", predNextPc, expPred);
        end
        @(posedge clk);
        #1;
    endtask

    // Wrong guess on an untrained opcode moves fetch anywhere
    task automatic jumpTo(pc_t pc);
        applyCycle(1'b0, makeResolve(OPC_OTHER, 32'h0, 1'b1, pc, pc + 32'd8));
        expectRedirect(1'b1);
    endtask

    task automatic finishTest(string name, int errorsBefore);
        int unsigned assertFails;
        // Failed bound assertions count as errors of the current test
        assertFails     = UUT.props.failCount;
        errorCount      += assertFails - assertFailsSeen;
        assertFailsSeen = assertFails;
        testCount++;
        if (errorCount == errorsBefore) begin
            $display("Test %0d (%s): passed", testCount, name);
        end else begin
            failedTests++;
            $display("Test %0d (%s): failed with %0d errors", testCount, name,
                     errorCount - errorsBefore);
        end
    endtask

    //------------------------------------------------------------
    // Watchdog
    //------------------------------------------------------------
    initial begin
        #((TEST_CYCLES + MARGIN_CYCLES) * 20);
        $display("Watchdog timeout: tests did not finish within %0d cycles",
                 TEST_CYCLES + MARGIN_CYCLES);
        $display("*** TEST FAILED ***");
        $finish;
    end

    //------------------------------------------------------------
    // Test sequence
    //------------------------------------------------------------
    initial begin
        int errorsBefore;
        void'($urandom(32'he33a5baf));
        rstN         = 1'b0;
        stall        = 1'b0;
        resolve      = NO_RESOLVE;
        lastRedirect = 1'b0;
        repeat (4) @(posedge clk);
        #1;
        rstN = 1'b1;

        errorsBefore = errorCount;
        for (int i = 0; i < 8; i++) begin
            applyCycle(1'b0, NO_RESOLVE);
        end
        expectFetch(`RESET_PC + 32'd32, `RESET_PC + 32'd36);
        finishTest("reset and sequential fetch", errorsBefore);

        errorsBefore = errorCount;
        jumpTo(32'h80);
        for (int i = 0; i < 4; i++) begin
            applyCycle(1'b1, NO_RESOLVE);
        end
        expectFetch(32'h80, 32'h84);
        applyCycle(1'b1, makeResolve(OPC_OTHER, 32'h40, 1'b1, 32'h300, 32'h44));
        expectRedirect(1'b1);
        expectFetch(32'h300, 32'h304);
        finishTest("stall hold and redirect under stall", errorsBefore);

        errorsBefore = errorCount;
        applyCycle(1'b0, makeResolve(OPC_BRANCH, 32'h100, 1'b1, 32'h180, 32'h104));
        applyCycle(1'b0, makeResolve(OPC_BRANCH, 32'h100, 1'b1, 32'h180, 32'h104));
        jumpTo(32'h100);
        expectFetch(32'h100, 32'h180);
        applyCycle(1'b0, makeResolve(OPC_BRANCH, 32'h100, 1'b0, 32'h180, 32'h180));
        // Counter was saturated, one not-taken still predicts taken
        jumpTo(32'h100);
        expectFetch(32'h100, 32'h180);
        applyCycle(1'b0, makeResolve(OPC_BRANCH, 32'h100, 1'b0, 32'h180, 32'h180));
        jumpTo(32'h100);
        expectFetch(32'h100, 32'h104);
        finishTest("counter and BTB training", errorsBefore);

        // 0x200 shares BTB index 0 with 0x100
        errorsBefore = errorCount;
        applyCycle(1'b0, makeResolve(OPC_BRANCH, 32'h100, 1'b1, 32'h180, 32'h104));
        jumpTo(32'h100);
        expectFetch(32'h100, 32'h180);
        applyCycle(1'b0, makeResolve(OPC_JAL, 32'h200, 1'b1, 32'h280, 32'h204));
        jumpTo(32'h100);
        expectFetch(32'h100, 32'h104);
        finishTest("BTB aliasing", errorsBefore);

        errorsBefore = errorCount;
        jumpTo(32'h400);
        applyCycle(1'b0, makeResolve(OPC_BRANCH, 32'h3F0, 1'b0, 32'h500, 32'h3F4));
        expectRedirect(1'b0);
        expectFetch(32'h404, 32'h408);
        applyCycle(1'b0, makeResolve(OPC_BRANCH, 32'h3F0, 1'b1, 32'h500, 32'h3F4));
        expectRedirect(1'b1);
        expectFetch(32'h500, 32'h504);
        finishTest("mispredict redirect", errorsBefore);

        errorsBefore = errorCount;
        for (int i = 0; i < RANDOM_CYCLES; i++) begin
            applyCycle(($urandom % 4) == 0, randomResolve());
        end
        finishTest("random resolves and stalls", errorsBefore);

        $display("Summary: %0d tests, %0d failed, %0d cycle checks, %0d errors",
                 testCount, failedTests, checkCount, errorCount);
        if (errorCount == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire
